/* files.f */
rtl/fetch_pkg.sv
rtl/fetch_pc_gen.sv
rtl/fetch_btb.sv
rtl/fetch_icache.sv
rtl/pre_decode.sv
rtl/fetch.sv
verification/fetch_props.sv
verification/fetch_tb.sv

/* rtl/fetch.sv */
`timescale 1ns/1ps

module fetch #(
  parameter logic [fetch_pkg::XLEN-1:0] RESET_PC     = fetch_pkg::RESET_PC,
  parameter int unsigned                ICACHE_LINES = fetch_pkg::ICACHE_LINES_DEF,
  parameter int unsigned                BTB_ENTRIES  = fetch_pkg::BTB_ENTRIES_DEF
) (
  input  logic                       clock,
  input  logic                       rst_n_i,

  output logic                       valid_post_o,
  input  logic                       ready_post_i,
  input  logic                       fetch_raw_i,
  output fetch_pkg::fetch_state_e    fetch_state_o,

  output logic [fetch_pkg::XLEN-1:0] pc_o,
  output logic [fetch_pkg::XLEN-1:0] inst_o,

  output logic                       fetch_rena1_o,
  output logic [4:0]                 fetch_raddr1_o,
  input  logic [fetch_pkg::XLEN-1:0] fetch_rdata1_i,
  output logic                       fetch_rena2_o,
  output logic [4:0]                 fetch_raddr2_o,
  input  logic [fetch_pkg::XLEN-1:0] fetch_rdata2_i,

  output logic                       arvalid_o,
  input  logic                       arready_i,
  output logic [fetch_pkg::XLEN-1:0] araddr_o,
  input  logic                       rvalid_i,
  input  logic                       rlast_i,
  input  logic [fetch_pkg::XLEN-1:0] rdata_i,
  output logic                       rready_o
);

  logic [fetch_pkg::XLEN-1:0] pc;
  logic                       accept;
  logic                       fire;
  fetch_pkg::pred_t           pred_btb;
  fetch_pkg::pred_t           pred_out;
  fetch_pkg::redirect_t       redirect;
  fetch_pkg::btb_upd_t        upd;
  fetch_pkg::fetch_out_t      out;

  assign fire   = valid_post_o && ready_post_i;
  assign pc_o   = out.pc;
  assign inst_o = out.inst;

  fetch_pc_gen #(.RESET_PC(RESET_PC)) fetch_pc_gen_inst (
    .clock      (clock),
    .rst_n_i    (rst_n_i),
    .accept_i   (accept),
    .pred_i     (pred_btb),
    .redirect_i (redirect),
    .pc_o       (pc)
  );

  fetch_btb #(.BTB_ENTRIES(BTB_ENTRIES)) fetch_btb_inst (
    .clock   (clock),
    .rst_n_i (rst_n_i),
    .pc_i    (pc),
    .pred_o  (pred_btb),
    .upd_i   (upd)
  );

  fetch_icache #(.ICACHE_LINES(ICACHE_LINES)) fetch_icache_inst (
    .clock        (clock),
    .rst_n_i      (rst_n_i),
    .pc_i         (pc),
    .pred_i       (pred_btb),
    .accept_o     (accept),
    .redirect_i   (redirect),
    .out_o        (out),
    .pred_o       (pred_out),
    .valid_post_o (valid_post_o),
    .ready_post_i (ready_post_i),
    .fetch_raw_i  (fetch_raw_i),
    .state_o      (fetch_state_o),
    .arvalid_o    (arvalid_o),
    .arready_i    (arready_i),
    .araddr_o     (araddr_o),
    .rvalid_i     (rvalid_i),
    .rlast_i      (rlast_i),
    .rdata_i      (rdata_i),
    .rready_o     (rready_o)
  );

  pre_decode pre_decode_inst (
    .valid_i        (valid_post_o),
    .out_i          (out),
    .pred_i         (pred_out),
    .fire_i         (fire),
    .fetch_rena1_o  (fetch_rena1_o),
    .fetch_raddr1_o (fetch_raddr1_o),
    .fetch_rdata1_i (fetch_rdata1_i),
    .fetch_rena2_o  (fetch_rena2_o),
    .fetch_raddr2_o (fetch_raddr2_o),
    .fetch_rdata2_i (fetch_rdata2_i),
    .redirect_o     (redirect),
    .upd_o          (upd)
  );

endmodule

/* rtl/fetch_btb.sv */
`timescale 1ns/1ps

module fetch_btb #(
  parameter int unsigned BTB_ENTRIES = fetch_pkg::BTB_ENTRIES_DEF
) (
  input  logic                       clock,
  input  logic                       rst_n_i,

  input  logic [fetch_pkg::XLEN-1:0] pc_i,
  output fetch_pkg::pred_t           pred_o,

  input  fetch_pkg::btb_upd_t        upd_i
);

  localparam int unsigned IDX_W = $clog2(BTB_ENTRIES);
  localparam int unsigned TAG_W = fetch_pkg::XLEN - IDX_W - 2;

  logic [BTB_ENTRIES-1:0]     entry_valid_q;
  logic [TAG_W-1:0]           tag_q    [BTB_ENTRIES];
  logic [fetch_pkg::XLEN-1:0] target_q [BTB_ENTRIES];

  logic [IDX_W-1:0] rd_idx;
  logic [TAG_W-1:0] rd_tag;
  logic [IDX_W-1:0] wr_idx;
  logic [TAG_W-1:0] wr_tag;
  logic             wr_match;

  assign rd_idx = pc_i[IDX_W+1:2]; // word index, the low two bits are always zero.
  assign rd_tag = pc_i[fetch_pkg::XLEN-1:IDX_W+2];
  assign wr_idx = upd_i.pc[IDX_W+1:2];
  assign wr_tag = upd_i.pc[fetch_pkg::XLEN-1:IDX_W+2];

  assign wr_match = entry_valid_q[wr_idx] && (tag_q[wr_idx] == wr_tag);

  assign pred_o.taken  = entry_valid_q[rd_idx] && (tag_q[rd_idx] == rd_tag);
  assign pred_o.target = target_q[rd_idx];

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      entry_valid_q <= '0;
    end else if (upd_i.valid) begin
      if (upd_i.taken) begin
        entry_valid_q[wr_idx] <= 1'b1;
      end else if (wr_match) begin
        entry_valid_q[wr_idx] <= 1'b0; // stop predicting a branch that fell through.
      end
    end
  end

  always_ff @(posedge clock) begin
    if (upd_i.valid && upd_i.taken) begin
      tag_q[wr_idx]    <= wr_tag;
      target_q[wr_idx] <= upd_i.target;
    end
  end

endmodule

/* rtl/fetch_icache.sv */
`timescale 1ns/1ps

module fetch_icache #(
  parameter int unsigned ICACHE_LINES = fetch_pkg::ICACHE_LINES_DEF
) (
  input  logic                       clock,
  input  logic                       rst_n_i,

  input  logic [fetch_pkg::XLEN-1:0] pc_i,
  input  fetch_pkg::pred_t           pred_i,
  output logic                       accept_o,
  input  fetch_pkg::redirect_t       redirect_i,

  output fetch_pkg::fetch_out_t      out_o,
  output fetch_pkg::pred_t           pred_o,
  output logic                       valid_post_o,
  input  logic                       ready_post_i,
  input  logic                       fetch_raw_i,
  output fetch_pkg::fetch_state_e    state_o,

  output logic                       arvalid_o,
  input  logic                       arready_i,
  output logic [fetch_pkg::XLEN-1:0] araddr_o,
  input  logic                       rvalid_i,
  input  logic                       rlast_i,
  input  logic [fetch_pkg::XLEN-1:0] rdata_i,
  output logic                       rready_o
);

  localparam int unsigned WORD_W = $clog2(fetch_pkg::LINE_WORDS);
  localparam int unsigned OFF_W  = WORD_W + 2;
  localparam int unsigned IDX_W  = $clog2(ICACHE_LINES);
  localparam int unsigned LINE_W = fetch_pkg::XLEN - OFF_W;
  localparam int unsigned TAG_W  = LINE_W - IDX_W;

  logic [ICACHE_LINES-1:0]    line_valid_q;
  logic [TAG_W-1:0]           tag_q  [ICACHE_LINES];
  logic [fetch_pkg::XLEN-1:0] data_q [ICACHE_LINES][fetch_pkg::LINE_WORDS];

  fetch_pkg::fetch_state_e state_q;
  logic [WORD_W-1:0]       beat_q;
  logic [LINE_W-1:0]       fill_line_q;

  fetch_pkg::fetch_out_t out_q;
  fetch_pkg::pred_t      pred_q;
  logic                  out_valid_q;

  logic [IDX_W-1:0]  idx;
  logic [TAG_W-1:0]  tag;
  logic [WORD_W-1:0] word;
  logic [IDX_W-1:0]  fill_idx;
  logic              hit;
  logic              fire;
  logic              reg_free;
  logic              lookup_ok;
  logic              miss_start;

  assign idx      = pc_i[OFF_W+IDX_W-1:OFF_W];
  assign tag      = pc_i[fetch_pkg::XLEN-1:OFF_W+IDX_W];
  assign word     = pc_i[OFF_W-1:2];
  assign fill_idx = fill_line_q[IDX_W-1:0];
  assign hit      = line_valid_q[idx] && (tag_q[idx] == tag);

  assign valid_post_o = out_valid_q && !fetch_raw_i;
  assign fire         = valid_post_o && ready_post_i;
  assign reg_free     = !out_valid_q || fire;

  // With the output register free or draining without a redirect, the pc is on the correct path.
  assign lookup_ok  = (state_q == fetch_pkg::FS_LOOKUP) && reg_free && !redirect_i.valid;
  assign accept_o   = lookup_ok && hit;
  assign miss_start = lookup_ok && !hit;

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      state_q      <= fetch_pkg::FS_LOOKUP;
      beat_q       <= '0;
      line_valid_q <= '0;
    end else begin
      case (state_q)
        fetch_pkg::FS_LOOKUP: begin
          if (miss_start) begin
            state_q           <= fetch_pkg::FS_AR;
            beat_q            <= '0;
            line_valid_q[idx] <= 1'b0; // the old line is overwritten beat by beat.
          end
        end
        fetch_pkg::FS_AR: begin
          if (arready_i) begin
            state_q <= fetch_pkg::FS_R;
          end
        end
        fetch_pkg::FS_R: begin
          if (rvalid_i) begin
            beat_q <= beat_q + 1'b1;
            if (rlast_i) begin
              state_q <= fetch_pkg::FS_FILL;
            end
          end
        end
        fetch_pkg::FS_FILL: begin
          line_valid_q[fill_idx] <= 1'b1;
          state_q                <= fetch_pkg::FS_LOOKUP;
        end
        default: state_q <= fetch_pkg::FS_LOOKUP;
      endcase
    end
  end

  always_ff @(posedge clock) begin
    if (miss_start) begin
      fill_line_q <= pc_i[fetch_pkg::XLEN-1:OFF_W];
    end
    if (state_q == fetch_pkg::FS_R && rvalid_i) begin
      data_q[fill_idx][beat_q] <= rdata_i;
    end
    if (state_q == fetch_pkg::FS_FILL) begin
      tag_q[fill_idx] <= fill_line_q[LINE_W-1:IDX_W];
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      out_valid_q <= 1'b0;
    end else if (accept_o) begin
      out_valid_q <= 1'b1;
    end else if (fire) begin
      out_valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (accept_o) begin
      out_q.pc   <= pc_i;
      out_q.inst <= data_q[idx][word];
      pred_q     <= pred_i;
    end
  end

  assign out_o    = out_q;
  assign pred_o   = pred_q;
  assign state_o  = state_q;

  assign arvalid_o = (state_q == fetch_pkg::FS_AR);
  assign araddr_o  = {fill_line_q, {OFF_W{1'b0}}};
  assign rready_o  = (state_q == fetch_pkg::FS_R);

endmodule

/* rtl/fetch_pc_gen.sv */
`timescale 1ns/1ps

module fetch_pc_gen #(
  parameter logic [fetch_pkg::XLEN-1:0] RESET_PC = fetch_pkg::RESET_PC
) (
  input  logic                       clock,
  input  logic                       rst_n_i,

  input  logic                       accept_i,
  input  fetch_pkg::pred_t           pred_i,
  input  fetch_pkg::redirect_t       redirect_i,

  output logic [fetch_pkg::XLEN-1:0] pc_o
);

  logic [fetch_pkg::XLEN-1:0] pc_q;
  logic [fetch_pkg::XLEN-1:0] pc_seq;
  logic [fetch_pkg::XLEN-1:0] pc_next;

  assign pc_seq = pc_q + 32'd4;

  always_comb begin
    if (redirect_i.valid) begin
      pc_next = redirect_i.target; // the resolved path wins over any prediction.
    end else if (accept_i) begin
      pc_next = pred_i.taken ? pred_i.target : pc_seq;
    end else begin
      pc_next = pc_q;
    end
  end

  always_ff @(posedge clock) begin
    if (!rst_n_i) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  assign pc_o = pc_q;

endmodule

/* rtl/fetch_pkg.sv */
package fetch_pkg;

  localparam int unsigned XLEN = 32;

  localparam logic [XLEN-1:0] RESET_PC = 32'h8000_0000;

  localparam int unsigned LINE_WORDS = 4; // one refill burst per line.

  localparam int unsigned ICACHE_LINES_DEF = 8;
  localparam int unsigned BTB_ENTRIES_DEF  = 8;

  typedef struct packed {
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] inst;
  } fetch_out_t;

  typedef struct packed {
    logic            taken;
    logic [XLEN-1:0] target; // only meaningful when taken is set.
  } pred_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] target;
  } redirect_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic            taken; // a clear bit removes a matching entry.
    logic [XLEN-1:0] target;
  } btb_upd_t;

  typedef enum logic [2:0] {
    FS_LOOKUP = 3'd0,
    FS_AR     = 3'd1,
    FS_R      = 3'd2,
    FS_FILL   = 3'd3
  } fetch_state_e;

  // Every other major opcode falls through as a plain instruction.
  typedef enum logic [6:0] {
    OP_JAL    = 7'b1101111,
    OP_BRANCH = 7'b1100011
  } opcode_e;

  typedef enum logic [2:0] {
    BEQ  = 3'b000,
    BNE  = 3'b001,
    BLT  = 3'b100,
    BGE  = 3'b101,
    BLTU = 3'b110,
    BGEU = 3'b111
  } br_funct_e;

endpackage

/* rtl/pre_decode.sv */
`timescale 1ns/1ps

module pre_decode (
  input  logic                       valid_i,
  input  fetch_pkg::fetch_out_t      out_i,
  input  fetch_pkg::pred_t           pred_i,
  input  logic                       fire_i,

  output logic                       fetch_rena1_o,
  output logic [4:0]                 fetch_raddr1_o,
  input  logic [fetch_pkg::XLEN-1:0] fetch_rdata1_i,

  output logic                       fetch_rena2_o,
  output logic [4:0]                 fetch_raddr2_o,
  input  logic [fetch_pkg::XLEN-1:0] fetch_rdata2_i,

  output fetch_pkg::redirect_t       redirect_o,
  output fetch_pkg::btb_upd_t        upd_o
);

  fetch_pkg::opcode_e   opcode;
  fetch_pkg::br_funct_e funct;

  logic [fetch_pkg::XLEN-1:0] inst;
  logic [fetch_pkg::XLEN-1:0] imm_j;
  logic [fetch_pkg::XLEN-1:0] imm_b;
  logic [fetch_pkg::XLEN-1:0] pc_seq;
  logic [fetch_pkg::XLEN-1:0] real_next;
  logic [fetch_pkg::XLEN-1:0] pred_next;
  logic                       is_jal;
  logic                       is_br;
  logic                       cond;
  logic                       real_taken;
  logic                       mispredict;

  assign inst   = out_i.inst;
  assign opcode = fetch_pkg::opcode_e'(inst[6:0]);
  assign funct  = fetch_pkg::br_funct_e'(inst[14:12]);

  assign imm_j = {{11{inst[31]}}, inst[31], inst[19:12], inst[20], inst[30:21], 1'b0};
  assign imm_b = {{19{inst[31]}}, inst[31], inst[7], inst[30:25], inst[11:8], 1'b0};

  assign is_jal = valid_i && (opcode == fetch_pkg::OP_JAL);
  assign is_br  = valid_i && (opcode == fetch_pkg::OP_BRANCH);

  assign fetch_rena1_o  = is_br;
  assign fetch_rena2_o  = is_br;
  assign fetch_raddr1_o = inst[19:15];
  assign fetch_raddr2_o = inst[24:20];

  always_comb begin
    case (funct)
      fetch_pkg::BEQ:  cond = (fetch_rdata1_i == fetch_rdata2_i);
      fetch_pkg::BNE:  cond = (fetch_rdata1_i != fetch_rdata2_i);
      fetch_pkg::BLT:  cond = ($signed(fetch_rdata1_i) < $signed(fetch_rdata2_i));
      fetch_pkg::BGE:  cond = ($signed(fetch_rdata1_i) >= $signed(fetch_rdata2_i));
      fetch_pkg::BLTU: cond = (fetch_rdata1_i < fetch_rdata2_i);
      fetch_pkg::BGEU: cond = (fetch_rdata1_i >= fetch_rdata2_i);
      default:         cond = 1'b0; // reserved funct3 values never branch.
    endcase
  end

  assign pc_seq     = out_i.pc + 32'd4;
  assign real_taken = is_jal || (is_br && cond);

  always_comb begin
    if (is_jal) begin
      real_next = out_i.pc + imm_j;
    end else if (is_br && cond) begin
      real_next = out_i.pc + imm_b;
    end else begin
      real_next = pc_seq;
    end
  end

  assign pred_next  = pred_i.taken ? pred_i.target : pc_seq;
  assign mispredict = (real_next != pred_next);

  assign redirect_o.valid  = fire_i && mispredict;
  assign redirect_o.target = real_next;

  assign upd_o.valid  = fire_i && mispredict; // the BTB only learns from mistakes.
  assign upd_o.pc     = out_i.pc;
  assign upd_o.taken  = real_taken;
  assign upd_o.target = real_next;

endmodule

/* run.sh */
#!/usr/bin/env bash
# Build and run the fetch unit testbench with Verilator.
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir build.log sim.log
verilator --binary --timing --assert -Wno-fatal --top-module fetch_tb -f files.f \
  -o fetch_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/fetch_sim > sim.log 2>&1
cat sim.log
grep -q "TESTBENCH PASSED" sim.log && echo "simulation ok" || { echo "simulation not ok"; exit 1; }

/* verification/fetch_props.sv */
`timescale 1ns/1ps

module fetch_props (
  input logic                       clock,
  input logic                       rst_n_i,
  input logic                       valid_post_o,
  input logic                       ready_post_i,
  input logic                       fetch_raw_i,
  input logic [fetch_pkg::XLEN-1:0] pc_o,
  input logic [fetch_pkg::XLEN-1:0] inst_o,
  input logic                       arvalid_o,
  input logic                       arready_i,
  input logic [fetch_pkg::XLEN-1:0] araddr_o
);

  localparam int OFF_W = $clog2(fetch_pkg::LINE_WORDS) + 2;

  stall_holds_output: assert property (@(posedge clock) disable iff (!rst_n_i)
    (valid_post_o && !ready_post_i) |=> ($stable(pc_o) && $stable(inst_o)))
    else $error("decode output changed while stalled.");

  hazard_blocks_valid: assert property (@(posedge clock) disable iff (!rst_n_i)
    fetch_raw_i |-> !valid_post_o)
    else $error("valid_post_o high during a register hazard.");

  ar_held_stable: assert property (@(posedge clock) disable iff (!rst_n_i)
    (arvalid_o && !arready_i) |=> (arvalid_o && $stable(araddr_o)))
    else $error("read address request dropped or changed before arready.");

  ar_line_aligned: assert property (@(posedge clock) disable iff (!rst_n_i)
    arvalid_o |-> (araddr_o[OFF_W-1:0] == '0))
    else $error("read address is not line aligned.");

endmodule

bind fetch fetch_props fetch_props_inst (
  .clock (clock), .rst_n_i (rst_n_i),
  .valid_post_o (valid_post_o), .ready_post_i (ready_post_i), .fetch_raw_i (fetch_raw_i),
  .pc_o (pc_o), .inst_o (inst_o),
  .arvalid_o (arvalid_o), .arready_i (arready_i), .araddr_o (araddr_o)
);

/* verification/fetch_tb.sv */
`timescale 1ns/1ps

module fetch_tb;

  localparam logic [31:0] BASE_PC   = fetch_pkg::RESET_PC;
  localparam int          MEM_WORDS = 64;
  localparam int          LOOP_INIT = 3;
  localparam int          N_ROWS    = 7;

  typedef struct packed {
    int prog;
    int ready_pct;
    int raw_pct;
    int ar_delay;
    int n_check;
  } row_t;

  // program, ready duty, hazard duty, arready delay, instructions to check.
  localparam row_t ROWS [N_ROWS] = '{
    '{0, 100, 0, 0, 120}, '{1, 100, 0, 2, 80}, '{2, 100, 0, 1, 150}, '{3, 100, 0, 0, 80},
    '{2, 60, 0, 3, 120}, '{0, 100, 40, 1, 100}, '{3, 50, 30, 2, 100}
  };

  logic                    clock = 1'b0;
  logic                    rst_n = 1'b0;
  logic                    ready_post = 1'b0;
  logic                    fetch_raw = 1'b0;
  logic                    arready = 1'b0;
  logic                    rvalid = 1'b0;
  logic                    rlast = 1'b0;
  logic [31:0]             mem_rdata = '0;
  logic                    valid_post;
  logic                    rena1;
  logic                    rena2;
  logic                    arvalid;
  logic                    rready;
  logic [4:0]              raddr1;
  logic [4:0]              raddr2;
  logic [31:0]             rdata1;
  logic [31:0]             rdata2;
  logic [31:0]             araddr;
  logic [31:0]             pc_out;
  logic [31:0]             inst_out;
  fetch_pkg::fetch_state_e state;

  logic [31:0]           mem [MEM_WORDS];
  int                    jump_to [MEM_WORDS]; // target word, or -1 for a plain instruction.
  logic                  is_cond [MEM_WORDS];
  fetch_pkg::br_funct_e  br_f [MEM_WORDS];
  logic [4:0]            br_a [MEM_WORDS];
  logic [4:0]            br_b [MEM_WORDS];
  fetch_pkg::fetch_out_t exp_q [$];

  logic [31:0] lcg_state = 32'h2b80_6223;
  int          loop_cnt = LOOP_INIT;
  int          cur_delay = 0;
  int          ar_wait = 0;
  int          beat = 0;
  logic [31:0] burst_addr = '0;

  always #20 clock = ~clock;

  fetch #(
    .RESET_PC     (BASE_PC),
    .ICACHE_LINES (8),
    .BTB_ENTRIES  (8)
  ) fetch_inst (
    .clock (clock), .rst_n_i (rst_n),
    .valid_post_o (valid_post), .ready_post_i (ready_post), .fetch_raw_i (fetch_raw),
    .fetch_state_o (state), .pc_o (pc_out), .inst_o (inst_out),
    .fetch_rena1_o (rena1), .fetch_raddr1_o (raddr1), .fetch_rdata1_i (rdata1),
    .fetch_rena2_o (rena2), .fetch_raddr2_o (raddr2), .fetch_rdata2_i (rdata2),
    .arvalid_o (arvalid), .arready_i (arready), .araddr_o (araddr),
    .rvalid_i (rvalid), .rlast_i (rlast), .rdata_i (mem_rdata), .rready_o (rready)
  );

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic pick(input int pct);
    return int'((lcg_next() >> 16) % 100) < pct;
  endfunction

  // x31 counts the loop down, every other register n reads n - 8.
  function automatic logic [31:0] reg_value(input logic [4:0] n, input int cnt);
    return (n == 5'd31) ? 32'(cnt) : 32'(n) - 32'd8;
  endfunction

  function automatic int next_count(input int cnt);
    return (cnt == 0) ? LOOP_INIT : cnt - 1;
  endfunction

  function automatic int word_index(input logic [31:0] addr);
    return int'((addr - BASE_PC) >> 2);
  endfunction

  function automatic logic [31:0] word_addr(input int i);
    return BASE_PC + 32'(i << 2);
  endfunction

  // an addi x0 whose immediate folds in every address bit.
  function automatic logic [31:0] plain_word(input logic [31:0] addr);
    logic [15:0] fold;
    fold = addr[31:16] ^ addr[15:0];
    return {fold[11:0] ^ {8'h00, fold[15:12]}, 13'h0000, 7'b0010011};
  endfunction

  function automatic logic cond_holds(input fetch_pkg::br_funct_e f, input logic [31:0] a,
                                      input logic [31:0] b);
    case (f)
      fetch_pkg::BEQ:  return a == b;
      fetch_pkg::BNE:  return a != b;
      fetch_pkg::BLT:  return $signed(a) < $signed(b);
      fetch_pkg::BGE:  return !($signed(a) < $signed(b));
      fetch_pkg::BLTU: return a < b;
      fetch_pkg::BGEU: return !(a < b);
      default:         return 1'b0;
    endcase
  endfunction

  function automatic string row_name(input int r);
    case (r)
      0: return "straight_cold";
      1: return "forward_jal";
      2: return "loop_btb";
      3: return "mixed_signs";
      4: return "loop_backpressure";
      5: return "straight_hazard";
      default: return "mixed_stress";
    endcase
  endfunction

  task automatic put_jal(input int at, input int to);
    logic [20:0] off;
    off = 21'((to - at) * 4);
    mem[at] = {off[20], off[10:1], off[11], off[19:12], 5'd0, fetch_pkg::OP_JAL};
    jump_to[at] = to;
  endtask

  task automatic put_br(input int at, input fetch_pkg::br_funct_e f, input logic [4:0] a,
                        input logic [4:0] b, input int to);
    logic [12:0] off;
    off = 13'((to - at) * 4);
    mem[at] = {off[12], off[10:5], b, a, f, off[4:1], off[11], fetch_pkg::OP_BRANCH};
    jump_to[at] = to;
    is_cond[at] = 1'b1;
    br_f[at] = f;
    br_a[at] = a;
    br_b[at] = b;
  endtask

  task automatic load_program(input int prog);
    for (int i = 0; i < MEM_WORDS; i++) begin
      mem[i] = plain_word(word_addr(i));
      jump_to[i] = -1;
      is_cond[i] = 1'b0;
    end
    case (prog)
      0: put_jal(40, 0); // eleven lines, more than the cache holds.
      1: begin
        put_jal(3, 8);
        put_br(11, fetch_pkg::BEQ, 5'd9, 5'd9, 16);
        put_jal(17, 0);
      end
      2: begin
        put_br(3, fetch_pkg::BNE, 5'd31, 5'd8, 1);
        put_jal(5, 0);
      end
      default: begin
        put_br(0, fetch_pkg::BLT, 5'd1, 5'd9, 2);
        put_br(2, fetch_pkg::BLTU, 5'd1, 5'd9, 5);
        put_br(3, fetch_pkg::BGEU, 5'd1, 5'd9, 6);
        put_br(6, fetch_pkg::BGE, 5'd1, 5'd9, 9);
        put_br(7, fetch_pkg::BEQ, 5'd3, 5'd3, 9);
        put_br(9, fetch_pkg::BNE, 5'd5, 5'd5, 12);
        put_jal(11, 0);
      end
    endcase
  endtask

  task automatic walk_program(input int n);
    logic [31:0] pc;
    int          cnt;
    int          idx;
    logic        taken;
    pc = BASE_PC;
    cnt = LOOP_INIT;
    exp_q.delete();
    for (int k = 0; k < n; k++) begin
      idx = word_index(pc);
      exp_q.push_back({pc, mem[idx]});
      if (jump_to[idx] < 0) begin
        pc = pc + 32'd4;
      end else if (!is_cond[idx]) begin
        pc = word_addr(jump_to[idx]);
      end else begin
        taken = cond_holds(br_f[idx], reg_value(br_a[idx], cnt), reg_value(br_b[idx], cnt));
        if (br_a[idx] == 5'd31) begin
          cnt = next_count(cnt);
        end
        pc = taken ? word_addr(jump_to[idx]) : pc + 32'd4;
      end
    end
  endtask

  task automatic stop_failed();
    $display("TESTBENCH FAILED");
    $fatal(1);
  endtask

  task automatic check_out(input string name, input fetch_pkg::fetch_out_t exp,
                           input fetch_pkg::fetch_out_t act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected pc=%h inst=%h, actual pc=%h inst=%h",
               name, exp.pc, exp.inst, act.pc, act.inst);
      stop_failed();
    end
  endtask

  task automatic check_state(input string name, input fetch_pkg::fetch_state_e exp,
                             input fetch_pkg::fetch_state_e act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected state %s, actual state %s", name, exp.name(), act.name());
      stop_failed();
    end
  endtask

  task automatic check_flag(input string name, input string what, input logic exp,
                            input logic act);
    if (act !== exp) begin
      $display("[ERROR] %s: expected %s %b, actual %b", name, what, exp, act);
      stop_failed();
    end
  endtask

  // the register file answers in the same cycle as the read address.
  assign rdata1 = reg_value(raddr1, loop_cnt);
  assign rdata2 = reg_value(raddr2, loop_cnt);

  always @(posedge clock) begin
    if (!rst_n) begin
      loop_cnt <= LOOP_INIT;
    end else if (valid_post && ready_post && rena1 && raddr1 == 5'd31) begin
      loop_cnt <= next_count(loop_cnt);
    end
  end

  always @(posedge clock) begin
    if (!rst_n) begin
      arready <= 1'b0;
      rvalid  <= 1'b0;
      rlast   <= 1'b0;
      ar_wait <= 0;
    end else if (arvalid && arready) begin
      if (araddr[3:0] != 4'h0 || araddr < BASE_PC || word_index(araddr) >= MEM_WORDS) begin
        $display("AXI read address %h is not line aligned inside the program", araddr);
        stop_failed();
      end
      arready    <= 1'b0;
      ar_wait    <= 0;
      burst_addr <= araddr;
      beat       <= 0;
      rvalid     <= 1'b1;
      mem_rdata  <= mem[word_index(araddr)];
      rlast      <= (fetch_pkg::LINE_WORDS == 1);
    end else if (arvalid) begin
      if (ar_wait >= cur_delay) begin
        arready <= 1'b1;
      end else begin
        ar_wait <= ar_wait + 1;
      end
    end else if (rvalid && rready) begin
      if (rlast) begin
        rvalid <= 1'b0;
        rlast  <= 1'b0;
      end else begin
        mem_rdata <= mem[word_index(burst_addr) + beat + 1];
        rlast     <= (beat + 2 == fetch_pkg::LINE_WORDS);
        beat      <= beat + 1;
      end
    end
  end

  task automatic run_row(input int r);
    row_t  row;
    string name;
    int    count;
    logic  exp_br;
    row = ROWS[r];
    name = row_name(r);
    cur_delay = row.ar_delay;
    rst_n <= 1'b0;
    ready_post <= 1'b0;
    fetch_raw <= 1'b0;
    load_program(row.prog);
    walk_program(row.n_check);
    repeat (10) @(posedge clock);
    check_state(name, fetch_pkg::FS_LOOKUP, state);
    check_flag(name, "valid_post", 1'b0, valid_post);
    check_flag(name, "arvalid", 1'b0, arvalid);
    check_flag(name, "rready", 1'b0, rready);
    check_flag(name, "rena1", 1'b0, rena1);
    check_flag(name, "rena2", 1'b0, rena2);
    rst_n <= 1'b1;
    count = 0;
    while (count < row.n_check) begin
      ready_post <= pick(row.ready_pct);
      fetch_raw <= pick(row.raw_pct);
      @(posedge clock);
      if (valid_post && ready_post) begin
        exp_br = is_cond[word_index(exp_q[count].pc)]; // only branches read registers.
        check_out(name, exp_q[count], {pc_out, inst_out});
        check_flag(name, "rena1", exp_br, rena1);
        check_flag(name, "rena2", exp_br, rena2);
        count++;
      end
    end
  endtask

  initial begin
    for (int r = 0; r < N_ROWS; r++) begin
      run_row(r);
    end
    $display("TESTBENCH PASSED");
    $finish;
  end

  initial begin
    int budget;
    budget = 0;
    for (int r = 0; r < N_ROWS; r++) begin
      budget += 200 * ROWS[r].n_check + 20;
    end
    repeat (budget) @(posedge clock);
    $display("timeout: the tests did not finish within %0d clock cycles", budget);
    stop_failed();
  end

endmodule
